/* verilog/mips_config.svh */
//==========================================================================
// sizes shared by the execute/memory/writeback datapath
// word width must stay 32, the lane and shift logic is written for 4 bytes
//==========================================================================
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// data word width in bits
`define MIPS_WORD_W 32

// bytes per word, one write enable per byte
`define MIPS_BYTES 4

// destination register index width
`define MIPS_REG_W 5

// shift amount width, fixed and variable shifts
`define MIPS_SHAMT_W 5

`endif

/* verilog/mips_pkg.sv */
//==========================================================================
// operation encodings and stage structs, the encodings are fixed values
//==========================================================================
`default_nettype none
`include "mips_config.svh"

package mips_pkg;

   typedef logic [`MIPS_WORD_W-1:0] word_t;
   typedef logic [`MIPS_REG_W-1:0]  reg_idx_t;
   // bit 3 is lane 31:24 (byte offset 0), bit 0 is lane 7:0
   typedef logic [`MIPS_BYTES-1:0]  byte_en_t;

   // alu operation, loads and stores always select add
   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_AND  = 4'd2,
      ALU_OR   = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_NOR  = 4'd5,
      ALU_SLT  = 4'd6,
      ALU_LUI  = 4'd7,
      ALU_SLL  = 4'd8,
      ALU_SRL  = 4'd9,
      ALU_SRA  = 4'd10,
      ALU_SLLV = 4'd11,
      ALU_SRLV = 4'd12,
      ALU_SRAV = 4'd13
   } alu_sel_e;

   // memory operation carried down the pipe
   typedef enum logic [3:0] {
      MEM_NONE = 4'd0,
      MEM_LB   = 4'd1,
      MEM_LBU  = 4'd2,
      MEM_LH   = 4'd3,
      MEM_LHU  = 4'd4,
      MEM_LW   = 4'd5,
      MEM_SB   = 4'd6,
      MEM_SH   = 4'd7,
      MEM_SW   = 4'd8
   } mem_op_e;

   // decoded operation as presented at issue
   typedef struct packed {
      alu_sel_e                 alu_sel;
      mem_op_e                  mem_op;
      logic [`MIPS_SHAMT_W-1:0] shamt;
      reg_idx_t                 dest;
   } exec_op_t;

   // execute to memory stage register
   typedef struct packed {
      logic     valid;
      exec_op_t op;
      word_t    result;
      word_t    store_data;
   } ex_mem_t;

   // fields the writeback stage works from
   typedef struct packed {
      mem_op_e  mem_op;
      reg_idx_t dest;
      word_t    result;
      logic [1:0] offset;
   } mem_wb_t;

endpackage

`default_nettype wire

/* verilog/exec_stage.sv */
//==========================================================================
// alu plus execute register, operands arrive already selected
//==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module exec_stage (
   input  logic               clk,
   input  logic               rst_b,
   input  logic               issue,
   input  mips_pkg::exec_op_t op,
   input  mips_pkg::word_t    op1,
   input  mips_pkg::word_t    op2,
   input  mips_pkg::word_t    store_word,
   output mips_pkg::ex_mem_t  ex_mem
);
   import mips_pkg::*;

   localparam int HALF_W = `MIPS_WORD_W / 2;

   word_t                    alu_result;
   // variable shifts take their count from rs, i.e. op1
   logic [`MIPS_SHAMT_W-1:0] var_shamt;
   logic                     lt_signed;

   assign var_shamt = op1[`MIPS_SHAMT_W-1:0];
   assign lt_signed = $signed(op1) < $signed(op2);

   // alu, one result per operation
   always_comb
   begin
      case (op.alu_sel)
         ALU_ADD:  alu_result = op1 + op2;
         ALU_SUB:  alu_result = op1 - op2;
         ALU_AND:  alu_result = op1 & op2;
         ALU_OR:   alu_result = op1 | op2;
         ALU_XOR:  alu_result = op1 ^ op2;
         ALU_NOR:  alu_result = ~(op1 | op2);
         // set on less than, two's complement compare
         ALU_SLT:  alu_result = {{(`MIPS_WORD_W-1){1'b0}}, lt_signed};
         // immediate half moves to the top, low half zero
         ALU_LUI:  alu_result = {op2[HALF_W-1:0], {HALF_W{1'b0}}};
         // fixed shifts move op1 by the shamt field
         ALU_SLL:  alu_result = op1 << op.shamt;
         ALU_SRL:  alu_result = op1 >> op.shamt;
         ALU_SRA:  alu_result = word_t'($signed(op1) >>> op.shamt);
         // variable shifts move op2 (rt) by op1 (rs)
         ALU_SLLV: alu_result = op2 << var_shamt;
         ALU_SRLV: alu_result = op2 >> var_shamt;
         ALU_SRAV: alu_result = word_t'($signed(op2) >>> var_shamt);
         default:  alu_result = '0;
      endcase
   end

   // stage register, valid follows issue every cycle
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         ex_mem <= '0;
      end
      else
      begin
         ex_mem.valid <= issue;
         // payload only moves when something is issued
         if (issue)
         begin
            ex_mem.op         <= op;
            ex_mem.result     <= alu_result;
            ex_mem.store_data <= store_word;
         end
      end
   end

   // the memory stage takes its byte address straight from the alu sum
   a_mem_op_adds : assert property (@(posedge clk) disable iff (!rst_b)
      issue && (op.mem_op != MEM_NONE) |-> (op.alu_sel == ALU_ADD))
      else $error("memory operation issued without add selection");

endmodule

`default_nettype wire

/* verilog/store_align.sv */
//==========================================================================
// big-endian store lane placement, memory must answer in the same cycle
//==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module store_align (
   input  mips_pkg::ex_mem_t       ex_mem,
   output logic [`MIPS_WORD_W-3:0] mem_addr,
   output mips_pkg::word_t         mem_data_in,
   output mips_pkg::byte_en_t      mem_write_en
);
   import mips_pkg::*;

   localparam int OFS_W = $clog2(`MIPS_BYTES);

   logic [OFS_W-1:0] offset;
   // offset in bits, byte 0 sits at the top of the word
   logic [OFS_W+2:0] lane_shift;
   byte_en_t         store_lanes;

   assign offset     = ex_mem.result[OFS_W-1:0];
   assign lane_shift = {offset, 3'b000};
   // word address, low bits pick the lane
   assign mem_addr   = ex_mem.result[`MIPS_WORD_W-1:OFS_W];

   always_comb
   begin
      mem_data_in = '0;
      store_lanes = '0;
      case (ex_mem.op.mem_op)
         MEM_SB:
         begin
            // byte starts in lane 0 and slides down by offset
            mem_data_in = {ex_mem.store_data[7:0], {(`MIPS_WORD_W-8){1'b0}}} >> lane_shift;
            store_lanes = byte_en_t'(4'b1000) >> offset;
         end
         MEM_SH:
         begin
            mem_data_in = {ex_mem.store_data[15:0], {(`MIPS_WORD_W-16){1'b0}}} >> lane_shift;
            store_lanes = byte_en_t'(4'b1100) >> offset;
         end
         MEM_SW:
         begin
            mem_data_in = ex_mem.store_data;
            store_lanes = '1;
         end
         default:
         begin
            mem_data_in = '0;
            store_lanes = '0;
         end
      endcase
   end

   // no write without a valid store in the memory stage
   assign mem_write_en = ex_mem.valid ? store_lanes : '0;

   // misaligned stores would straddle words, upstream must not send them
   always_comb
   begin
      if (ex_mem.valid && (ex_mem.op.mem_op == MEM_SH))
      begin
         assert (!offset[0])
            else $error("sh at odd byte offset %0d", offset);
      end
      if (ex_mem.valid && (ex_mem.op.mem_op == MEM_SW))
      begin
         assert (offset == '0)
            else $error("sw at nonzero byte offset %0d", offset);
      end
   end

endmodule

`default_nettype wire

/* verilog/wb_stage.sv */
//==========================================================================
// load extract and extend, writeback register, stores never write back
//==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module wb_stage (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::ex_mem_t  ex_mem,
   input  mips_pkg::word_t    mem_data_out,
   output logic               wb_valid,
   output mips_pkg::reg_idx_t wb_dest,
   output mips_pkg::word_t    wb_data
);
   import mips_pkg::*;

   mem_wb_t mem_wb;
   // loaded word moved so the addressed byte lands in 31:24
   word_t   lane_data;
   word_t   wb_value;
   logic    is_store;
   logic    wb_take;

   always_comb
   begin
      mem_wb.mem_op = ex_mem.op.mem_op;
      mem_wb.dest   = ex_mem.op.dest;
      mem_wb.result = ex_mem.result;
      mem_wb.offset = ex_mem.result[1:0];
   end

   assign lane_data = mem_data_out << {mem_wb.offset, 3'b000};
   assign is_store  = mem_wb.mem_op inside {MEM_SB, MEM_SH, MEM_SW};
   assign wb_take   = ex_mem.valid && !is_store;

   // writeback value select
   always_comb
   begin
      case (mem_wb.mem_op)
         MEM_LB:  wb_value = {{(`MIPS_WORD_W-8){lane_data[31]}}, lane_data[31:24]};
         MEM_LBU: wb_value = {{(`MIPS_WORD_W-8){1'b0}}, lane_data[31:24]};
         MEM_LH:  wb_value = {{(`MIPS_WORD_W-16){lane_data[31]}}, lane_data[31:16]};
         MEM_LHU: wb_value = {{(`MIPS_WORD_W-16){1'b0}}, lane_data[31:16]};
         MEM_LW:  wb_value = mem_data_out;
         // alu operations pass their result through
         default: wb_value = mem_wb.result;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         wb_valid <= 1'b0;
         wb_dest  <= '0;
         wb_data  <= '0;
      end
      else
      begin
         // one pulse per non-store operation
         wb_valid <= wb_take;
         if (wb_take)
         begin
            wb_dest <= mem_wb.dest;
            wb_data <= wb_value;
         end
      end
   end

   // half loads must be aligned by the address computed in execute
   a_half_aligned : assert property (@(posedge clk) disable iff (!rst_b)
      ex_mem.valid && (mem_wb.mem_op inside {MEM_LH, MEM_LHU}) |-> !mem_wb.offset[0])
      else $error("half load at odd byte offset");

endmodule

`default_nettype wire

/* verilog/mips_exec_mem.sv */
//==========================================================================
// execute, memory and writeback back end, fixed 2-cycle latency
// no back-pressure, one operation accepted on every issue edge
//==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module mips_exec_mem (
   input  logic                    clk,
   input  logic                    rst_b,
   // issue side
   input  logic                    issue,
   input  mips_pkg::exec_op_t      op,
   input  mips_pkg::word_t         op1,
   input  mips_pkg::word_t         op2,
   input  mips_pkg::word_t         store_word,
   // data memory, read data returns in the same cycle
   output logic [`MIPS_WORD_W-3:0] mem_addr,
   output mips_pkg::word_t         mem_data_in,
   output mips_pkg::byte_en_t      mem_write_en,
   input  mips_pkg::word_t         mem_data_out,
   // register write
   output logic                    wb_valid,
   output mips_pkg::reg_idx_t      wb_dest,
   output mips_pkg::word_t         wb_data
);
   import mips_pkg::*;

   // memory stage contents, feeds both store lanes and load extract
   ex_mem_t ex_mem;

   exec_stage u_exec (
      .clk        (clk),
      .rst_b      (rst_b),
      .issue      (issue),
      .op         (op),
      .op1        (op1),
      .op2        (op2),
      .store_word (store_word),
      .ex_mem     (ex_mem)
   );

   store_align u_store (
      .ex_mem       (ex_mem),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en)
   );

   wb_stage u_wb (
      .clk          (clk),
      .rst_b        (rst_b),
      .ex_mem       (ex_mem),
      .mem_data_out (mem_data_out),
      .wb_valid     (wb_valid),
      .wb_dest      (wb_dest),
      .wb_data      (wb_data)
   );

endmodule

`default_nettype wire

/* test/tb_mips_exec_mem.sv */
//==========================================================================
// runs from the project root so the test file path resolves
// memory model holds 16 words and test addresses stay below byte 64
//==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "mips_config.svh"

module tb_mips_exec_mem;
   import mips_pkg::*;

   localparam int MAX_TESTS  = 64;
   // edges from the sampling edge to the writeback cycle
   localparam int WB_LATENCY = 2;

   logic                    clk;
   logic                    rst_b;
   logic                    issue;
   exec_op_t                op;
   word_t                   op1;
   word_t                   op2;
   word_t                   store_word;
   logic [`MIPS_WORD_W-3:0] mem_addr;
   word_t                   mem_data_in;
   byte_en_t                mem_write_en;
   word_t                   mem_data_out;
   logic                    wb_valid;
   reg_idx_t                wb_dest;
   word_t                   wb_data;

   // one table entry per data line
   logic [8*16-1:0] t_name  [0:MAX_TESTS-1];
   logic [3:0]      t_alu   [0:MAX_TESTS-1];
   logic [3:0]      t_mem   [0:MAX_TESTS-1];
   logic [4:0]      t_shamt [0:MAX_TESTS-1];
   logic [4:0]      t_dest  [0:MAX_TESTS-1];
   word_t           t_op1   [0:MAX_TESTS-1];
   word_t           t_op2   [0:MAX_TESTS-1];
   word_t           t_sw    [0:MAX_TESTS-1];
   // writeback value or memory word after a store
   word_t           t_exp   [0:MAX_TESTS-1];

   int    test_count;
   int    pass_count;
   int    fail_count;
   logic  test_ok;
   logic  load_ok;
   int    cycle_count = 0;
   int    cycle_limit = 0;
   word_t mem [0:15];

   mips_exec_mem dut (
      .clk          (clk),
      .rst_b        (rst_b),
      .issue        (issue),
      .op           (op),
      .op1          (op1),
      .op2          (op2),
      .store_word   (store_word),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en),
      .mem_data_out (mem_data_out),
      .wb_valid     (wb_valid),
      .wb_dest      (wb_dest),
      .wb_data      (wb_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // combinational read of the data memory
   assign mem_data_out = mem[mem_addr[3:0]];

   always @(posedge clk)
   begin
      if (!rst_b)
      begin
         // fill pattern differs between neighbouring words in every byte
         for (int i = 0; i < 16; i++)
            mem[i] <= 32'h1020_3040 + word_t'(i) * 32'h0101_0101;
      end
      else
      begin
         // enabled lanes only
         for (int b = 0; b < `MIPS_BYTES; b++)
            if (mem_write_en[b])
               mem[mem_addr[3:0]][8*b +: 8] <= mem_data_in[8*b +: 8];
      end
   end

   // watchdog
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit)
      begin
         $display("timeout, the run did not finish within %0d cycles", cycle_limit);
         $display("Simulation FAILED");
         $finish;
      end
   end

   function automatic logic is_store_op(input logic [3:0] m);
      return (m == MEM_SB) || (m == MEM_SH) || (m == MEM_SW);
   endfunction

   task automatic compare_word(input logic [8*16-1:0] name, input string what,
                               input word_t expected, input word_t actual);
      if (expected !== actual)
      begin
         $display("CHECK FAILED %0s %0s expected %h actual %h", name, what, expected, actual);
         test_ok = 1'b0;
      end
   endtask

   task automatic finish_test(input logic [8*16-1:0] name);
      if (test_ok)
      begin
         pass_count++;
         $display("PASS %0s", name);
      end
      else
      begin
         fail_count++;
         $display("FAIL %0s", name);
      end
   endtask

   task automatic load_tests(output logic ok);
      int    fd;
      int    code;
      int    count;
      string line;
      ok = 1'b0;
      test_count = 0;
      fd = $fopen("test/exec_input.txt", "r");
      if (fd != 0)
      begin
         ok = 1'b1;
         while (!$feof(fd) && test_count < MAX_TESTS)
         begin
            code = $fgets(line, fd);
            // lines starting with # name the columns
            if (code > 0 && line.getc(0) != "#")
            begin
               count = $sscanf(line, "%s %h %h %h %h %h %h %h %h", t_name[test_count],
                               t_alu[test_count], t_mem[test_count], t_shamt[test_count],
                               t_dest[test_count], t_op1[test_count], t_op2[test_count],
                               t_sw[test_count], t_exp[test_count]);
               // blank lines give no field at all
               if (count == 9)
                  test_count++;
               else if (count > 0)
               begin
                  $display("malformed line in the test file after test %0d", test_count);
                  ok = 1'b0;
               end
            end
         end
         $fclose(fd);
      end
      if (test_count == 0)
         ok = 1'b0;
   endtask

   task automatic check_idle(input logic [8*16-1:0] name);
      compare_word(name, "mem_write_en", '0, word_t'(mem_write_en));
      compare_word(name, "wb_valid", '0, word_t'(wb_valid));
      compare_word(name, "mem_addr", '0, word_t'(mem_addr));
      compare_word(name, "mem_data_in", '0, mem_data_in);
      compare_word(name, "wb_dest", '0, word_t'(wb_dest));
      compare_word(name, "wb_data", '0, wb_data);
   endtask

   task automatic check_reset();
      test_ok = 1'b1;
      repeat (16)
      begin
         @(negedge clk);
         check_idle("reset");
      end
      @(posedge clk);
      rst_b <= 1'b1;
      issue <= 1'b0;
      // first cycle out of reset
      @(negedge clk);
      check_idle("reset");
      finish_test("reset");
   endtask

   task automatic issue_op(input int i);
      @(posedge clk);
      issue      <= 1'b1;
      op.alu_sel <= alu_sel_e'(t_alu[i]);
      op.mem_op  <= mem_op_e'(t_mem[i]);
      op.shamt   <= t_shamt[i];
      op.dest    <= t_dest[i];
      op1        <= t_op1[i];
      op2        <= t_op2[i];
      store_word <= t_sw[i];
   endtask

   // one operation alone in the pipe
   task automatic run_test(input int i);
      int    waited;
      logic  seen;
      word_t addr;
      test_ok = 1'b1;
      // byte address is the add of the two operands
      addr = t_op1[i] + t_op2[i];
      issue_op(i);
      @(posedge clk);
      issue <= 1'b0;
      if (is_store_op(t_mem[i]))
      begin
         for (int c = 1; c <= WB_LATENCY; c++)
         begin
            @(negedge clk);
            // first negedge falls in the memory cycle
            if (c == 1)
               compare_word(t_name[i], "mem_addr", addr >> 2, word_t'(mem_addr));
            if (wb_valid)
            begin
               $display("%0s raised wb_valid although it is a store", t_name[i]);
               test_ok = 1'b0;
            end
         end
         compare_word(t_name[i], "memory word", t_exp[i], mem[addr[5:2]]);
      end
      else
      begin
         waited = 0;
         seen   = 1'b0;
         while (!seen && waited < 2 * WB_LATENCY)
         begin
            @(negedge clk);
            waited++;
            if (waited == 1 && t_mem[i] != MEM_NONE)
               compare_word(t_name[i], "mem_addr", addr >> 2, word_t'(mem_addr));
            seen = wb_valid;
         end
         if (!seen)
         begin
            $display("%0s produced no writeback within %0d cycles", t_name[i], waited);
            test_ok = 1'b0;
         end
         else
         begin
            if (waited != WB_LATENCY)
            begin
               $display("%0s wrote back after %0d cycles instead of %0d", t_name[i],
                        waited, WB_LATENCY);
               test_ok = 1'b0;
            end
            compare_word(t_name[i], "wb_data", t_exp[i], wb_data);
            compare_word(t_name[i], "wb_dest", word_t'(t_dest[i]), word_t'(wb_dest));
         end
      end
      finish_test(t_name[i]);
   endtask

   // whole table issued on consecutive cycles with writebacks in issue order
   task automatic stream_tests();
      word_t           exp_q  [$];
      word_t           dest_q [$];
      logic [8*16-1:0] name_q [$];
      logic [8*16-1:0] name;
      int              pulses;
      int              expected;
      test_ok  = 1'b1;
      pulses   = 0;
      expected = 0;
      for (int i = 0; i < test_count + WB_LATENCY + 1; i++)
      begin
         if (i < test_count)
         begin
            issue_op(i);
            if (!is_store_op(t_mem[i]))
            begin
               exp_q.push_back(t_exp[i]);
               dest_q.push_back(word_t'(t_dest[i]));
               name_q.push_back(t_name[i]);
               expected++;
            end
         end
         else
         begin
            @(posedge clk);
            issue <= 1'b0;
         end
         @(negedge clk);
         if (wb_valid)
         begin
            pulses++;
            if (exp_q.size() == 0)
            begin
               $display("writeback pulse with no load or alu operation outstanding");
               test_ok = 1'b0;
            end
            else
            begin
               name = name_q.pop_front();
               compare_word(name, "streamed wb_data", exp_q.pop_front(), wb_data);
               compare_word(name, "streamed wb_dest", dest_q.pop_front(), word_t'(wb_dest));
            end
         end
      end
      if (pulses != expected)
      begin
         $display("streamed run gave %0d writeback pulses, %0d were due", pulses, expected);
         test_ok = 1'b0;
      end
      finish_test("back_to_back");
   endtask

   initial
   begin
      rst_b      <= 1'b0;
      // a store held at issue during reset must never reach memory
      issue      <= 1'b1;
      op         <= '{ALU_ADD, MEM_SW, 5'd0, 5'd0};
      op1        <= '0;
      op2        <= 32'h0000_0008;
      store_word <= 32'hdead_beef;
      pass_count = 0;
      fail_count = 0;
      load_tests(load_ok);
      cycle_limit = 16 + 4 * test_count + 20;
      if (!load_ok)
      begin
         $display("could not read a valid test table from test/exec_input.txt");
         $display("Simulation FAILED");
         $finish;
      end
      else
      begin
         check_reset();
         for (int i = 0; i < test_count; i++)
            run_test(i);
         stream_tests();
         $display("tests run %0d, passed %0d, failed %0d", pass_count + fail_count,
                  pass_count, fail_count);
         if (fail_count == 0)
            $display("Simulation PASSED");
         else
            $display("Simulation FAILED");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* test/exec_input.txt */
# name alu_sel mem_op shamt dest op1 op2 store_word expected, hex after the name
# expected is the writeback value, or the memory word after an sb, sh or sw
add      0 0 00 01 00000005 00000007 00000000 0000000c
sub      1 0 00 02 00000010 00000020 00000000 fffffff0
and      2 0 00 03 f0f0ff00 0ff00ff0 00000000 00f00f00
or       3 0 00 04 f0f0ff00 0ff00ff0 00000000 fff0fff0
xor      4 0 00 05 f0f0ff00 0ff00ff0 00000000 ff00f0f0
nor      5 0 00 06 f0f0ff00 0ff00ff0 00000000 000f000f
slt_neg  6 0 00 07 ffffffff 00000001 00000000 00000001
slt_pos  6 0 00 08 00000001 ffffffff 00000000 00000000
lui      7 0 00 09 00000000 0000abcd 00000000 abcd0000
sll      8 0 04 0a 0000000f 00000000 00000000 000000f0
srl      9 0 08 0b 80000000 00000000 00000000 00800000
sra      a 0 08 0c 80000000 00000000 00000000 ff800000
sllv     b 0 00 0d 00000003 00000001 00000000 00000008
srlv     c 0 00 0e 00000024 f0000000 00000000 0f000000
srav     d 0 00 0f 00000024 f0000000 00000000 ff000000
sb_0     0 6 00 00 00000004 00000000 123456aa aa213141
sb_1     0 6 00 00 00000004 00000001 000000bb aabb3141
sb_2     0 6 00 00 00000004 00000002 000000cc aabbcc41
sb_3     0 6 00 00 00000004 00000003 000000dd aabbccdd
sh_0     0 7 00 00 00000008 00000000 99998765 87653242
sh_2     0 7 00 00 00000008 00000002 00001234 87651234
sw       0 8 00 00 0000000c 00000000 89abcdef 89abcdef
lb_neg   0 1 00 10 00000004 00000000 00000000 ffffffaa
lbu      0 2 00 11 00000004 00000000 00000000 000000aa
lb_pos   0 1 00 12 00000008 00000003 00000000 00000034
lh_neg   0 3 00 13 00000008 00000000 00000000 ffff8765
lhu      0 4 00 14 00000008 00000000 00000000 00008765
lw       0 5 00 15 0000000c 00000000 00000000 89abcdef

/* project.f */
+incdir+verilog
verilog/mips_pkg.sv
verilog/exec_stage.sv
verilog/store_align.sv
verilog/wb_stage.sv
verilog/mips_exec_mem.sv
test/tb_mips_exec_mem.sv

/* Makefile */
# Verilator build and run of the execute, memory and writeback testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f project.f \
		--top-module tb_mips_exec_mem -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
